//--- soc_bus_pkg.sv
package soc_bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w   = data_w / 8;

  // Master request, fields stay stable while req is high
  typedef struct packed {
    logic              req;
    logic              write;
    logic [be_w-1:0]   be;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // Slave response, ack is a one cycle pulse
  typedef struct packed {
    logic              ack;
    logic              err;
    logic [data_w-1:0] rdata;
  } bus_rsp_t;

endpackage

//--- soc_periph_pkg.sv
package soc_periph_pkg;

  localparam int adc_sample_w    = 12;
  localparam int shield_win_bits = 12;

  // Byte offsets inside the shield window
  localparam logic [shield_win_bits-1:0] reg_ctrl     = 12'h000;
  localparam logic [shield_win_bits-1:0] reg_status   = 12'h004;
  localparam logic [shield_win_bits-1:0] reg_gpio_out = 12'h008;
  localparam logic [shield_win_bits-1:0] reg_gpio_oe  = 12'h00C;
  localparam logic [shield_win_bits-1:0] reg_gpio_in  = 12'h010;

  // reg_ctrl holds the channel in bits 2..0 and start here
  localparam int ctrl_start_bit = 3;

  // Config word sent MSB first on SDI
  typedef struct packed {
    logic       single_ended;
    logic       odd_sign;
    logic [1:0] select;
    logic       unipolar;
    logic       sleep;
  } adc_cfg_t;

  typedef struct packed {
    logic                    busy;
    logic                    valid;
    logic [2:0]              channel;
    logic [adc_sample_w-1:0] sample;
  } adc_status_t;

endpackage

//--- soc_mem.sv
`timescale 1ns/10ps

module soc_mem #(
  parameter int                              ADDR_BITS = 10,
  parameter logic [soc_bus_pkg::addr_w-1:0] BASE      = 32'h0001_0000
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  soc_bus_pkg::bus_req_t bus_req,
  output soc_bus_pkg::bus_rsp_t bus_rsp
);

  localparam int hi    = soc_bus_pkg::addr_w - 1;
  localparam int words = 2 ** (ADDR_BITS - 2);

  logic [soc_bus_pkg::data_w-1:0] mem [words];
  logic [soc_bus_pkg::data_w-1:0] rdata_q;
  logic [ADDR_BITS-3:0]           word_addr;
  logic                           hit;
  logic                           access;
  logic                           ack_q;

  // Window of 2^ADDR_BITS bytes at BASE
  assign hit       = bus_req.req && (bus_req.addr[hi:ADDR_BITS] == BASE[hi:ADDR_BITS]);
  assign access    = hit && !ack_q;
  assign word_addr = bus_req.addr[ADDR_BITS-1:2];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      ack_q <= 1'b0;
    else
      ack_q <= access;
  end

  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (bus_req.write)
      begin
        for (int i = 0; i < soc_bus_pkg::be_w; i++)
        begin
          if (bus_req.be[i])
            mem[word_addr][8*i +: 8] <= bus_req.wdata[8*i +: 8];
        end
      end
      rdata_q <= mem[word_addr];
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.err   = 1'b0;
  assign bus_rsp.rdata = ack_q ? rdata_q : '0;

endmodule

//--- soc_led.sv
`timescale 1ns/10ps

module soc_led #(
  parameter logic [soc_bus_pkg::addr_w-1:0] BASE = 32'hC000_0000
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  soc_bus_pkg::bus_req_t bus_req,
  output soc_bus_pkg::bus_rsp_t bus_rsp,
  output logic [7:0]            led
);

  localparam int hi = soc_bus_pkg::addr_w - 1;

  logic hit;
  logic access;
  logic ack_q;

  // Only the one word at BASE
  assign hit    = bus_req.req && (bus_req.addr[hi:2] == BASE[hi:2]);
  assign access = hit && !ack_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ack_q <= 1'b0;
      led   <= '0;
    end
    else
    begin
      ack_q <= access;
      if (access && bus_req.write && bus_req.be[0])
        led <= bus_req.wdata[7:0];
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.err   = 1'b0;
  assign bus_rsp.rdata = ack_q ? {{(soc_bus_pkg::data_w-8){1'b0}}, led} : '0;

endmodule

//--- soc_adc_ctrl.sv
`timescale 1ns/10ps

module soc_adc_ctrl #(
  parameter int SCK_DIV = 2
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        start,
  input  logic [2:0]                  channel,
  output soc_periph_pkg::adc_status_t status,
  output logic                        adc_convst,
  output logic                        adc_sck,
  output logic                        adc_sdi,
  input  logic                        adc_sdo
);

  localparam int sample_w    = soc_periph_pkg::adc_sample_w;
  localparam int cfg_w       = $bits(soc_periph_pkg::adc_cfg_t);
  localparam int conv_cycles = 4;
  localparam int cnt_w       = $clog2(conv_cycles + SCK_DIV + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_convert,
    st_shift
  } state_t;

  state_t                   state;
  logic [cnt_w-1:0]         cnt;
  logic [3:0]               bit_cnt;
  logic [sample_w-1:0]      tx_q;
  logic [sample_w-1:0]      rx_q;
  logic [sample_w-1:0]      sample_q;
  logic [2:0]               chan_q;
  logic                     valid_q;
  logic                     sck_edge;
  soc_periph_pkg::adc_cfg_t cfg;

  // Channel bit 0 picks odd/sign, bits 2..1 the select field
  assign cfg = '{
    single_ended: 1'b1,
    odd_sign:     chan_q[0],
    select:       chan_q[2:1],
    unipolar:     1'b1,
    sleep:        1'b0
  };

  // SCK toggles every SCK_DIV cycles while shifting
  assign sck_edge = (state == st_shift) && (cnt == cnt_w'(SCK_DIV - 1));

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= st_idle;
      cnt        <= '0;
      bit_cnt    <= '0;
      tx_q       <= '0;
      sample_q   <= '0;
      chan_q     <= '0;
      valid_q    <= 1'b0;
      adc_convst <= 1'b0;
      adc_sck    <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (start)
          begin
            state      <= st_convert;
            cnt        <= '0;
            chan_q     <= channel;
            valid_q    <= 1'b0;
            adc_convst <= 1'b1;
          end
        end
        st_convert:
        begin
          if (cnt == cnt_w'(conv_cycles - 1))
          begin
            state      <= st_shift;
            cnt        <= '0;
            bit_cnt    <= '0;
            tx_q       <= {cfg, {(sample_w - cfg_w){1'b0}}};
            adc_convst <= 1'b0;
          end
          else
            cnt <= cnt + 1'b1;
        end
        st_shift:
        begin
          if (sck_edge)
          begin
            cnt     <= '0;
            adc_sck <= !adc_sck;
            // Falling edge moves SDI on, or ends after the last bit
            if (adc_sck)
            begin
              if (bit_cnt == 4'(sample_w - 1))
              begin
                state    <= st_idle;
                valid_q  <= 1'b1;
                sample_q <= rx_q;
                tx_q     <= '0;
              end
              else
              begin
                bit_cnt <= bit_cnt + 1'b1;
                tx_q    <= tx_q << 1;
              end
            end
          end
          else
            cnt <= cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // SDO sampled as SCK rises
  always_ff @(posedge clk)
  begin
    if (sck_edge && !adc_sck)
      rx_q <= {rx_q[sample_w-2:0], adc_sdo};
  end

  assign adc_sdi = tx_q[sample_w-1];

  assign status = '{
    busy:    (state != st_idle),
    valid:   valid_q,
    channel: chan_q,
    sample:  sample_q
  };

endmodule

//--- soc_shield.sv
`timescale 1ns/10ps

module soc_shield #(
  parameter logic [soc_bus_pkg::addr_w-1:0] BASE    = 32'hC000_1000,
  parameter int                              SCK_DIV = 2
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  soc_bus_pkg::bus_req_t bus_req,
  output soc_bus_pkg::bus_rsp_t bus_rsp,
  output logic                  adc_convst,
  output logic                  adc_sck,
  output logic                  adc_sdi,
  input  logic                  adc_sdo,
  input  logic [15:0]           gpio_in,
  output logic [15:0]           gpio_out,
  output logic [15:0]           gpio_oe
);

  localparam int hi  = soc_bus_pkg::addr_w - 1;
  localparam int dw  = soc_bus_pkg::data_w;
  localparam int win = soc_periph_pkg::shield_win_bits;

  logic                        hit;
  logic                        access;
  logic                        wr;
  logic                        ack_q;
  logic                        adc_start;
  logic [win-1:0]              offset;
  logic [15:0]                 gpio_in_meta;
  logic [15:0]                 gpio_in_sync;
  logic [dw-1:0]               rd_mux;
  logic [dw-1:0]               rdata_q;
  soc_periph_pkg::adc_status_t adc_status;

  assign hit    = bus_req.req && (bus_req.addr[hi:win] == BASE[hi:win]);
  assign offset = bus_req.addr[win-1:0];
  assign access = hit && !ack_q;
  assign wr     = access && bus_req.write;

  assign adc_start = wr && (offset == soc_periph_pkg::reg_ctrl) && bus_req.be[0] &&
                     bus_req.wdata[soc_periph_pkg::ctrl_start_bit];

  always_comb
  begin
    rd_mux = '0;
    case (offset)
      soc_periph_pkg::reg_ctrl:
      begin
        rd_mux[2:0]                           = adc_status.channel;
        rd_mux[soc_periph_pkg::ctrl_start_bit] = adc_status.busy;
      end
      soc_periph_pkg::reg_status:
        rd_mux = {{(dw - $bits(adc_status)){1'b0}}, adc_status};
      soc_periph_pkg::reg_gpio_out:
        rd_mux[15:0] = gpio_out;
      soc_periph_pkg::reg_gpio_oe:
        rd_mux[15:0] = gpio_oe;
      soc_periph_pkg::reg_gpio_in:
        rd_mux[15:0] = gpio_in_sync;
      default:
        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ack_q        <= 1'b0;
      gpio_out     <= '0;
      gpio_oe      <= '0;
      gpio_in_meta <= '0;
      gpio_in_sync <= '0;
    end
    else
    begin
      ack_q        <= access;
      gpio_in_meta <= gpio_in;
      gpio_in_sync <= gpio_in_meta;
      // Two byte lanes per GPIO register
      for (int i = 0; i < 2; i++)
      begin
        if (wr && bus_req.be[i] && offset == soc_periph_pkg::reg_gpio_out)
          gpio_out[8*i +: 8] <= bus_req.wdata[8*i +: 8];
        if (wr && bus_req.be[i] && offset == soc_periph_pkg::reg_gpio_oe)
          gpio_oe[8*i +: 8] <= bus_req.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
      rdata_q <= rd_mux;
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.err   = 1'b0;
  assign bus_rsp.rdata = ack_q ? rdata_q : '0;

  soc_adc_ctrl #(
    .SCK_DIV (SCK_DIV)
  ) adc_ctrl_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (adc_start),
    .channel    (bus_req.wdata[2:0]),
    .status     (adc_status),
    .adc_convst (adc_convst),
    .adc_sck    (adc_sck),
    .adc_sdi    (adc_sdi),
    .adc_sdo    (adc_sdo)
  );

endmodule

//--- soc_bus_join.sv
`timescale 1ns/10ps

module soc_bus_join #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  soc_bus_pkg::bus_req_t host_req,
  input  soc_bus_pkg::bus_rsp_t mem_rsp,
  input  soc_bus_pkg::bus_rsp_t led_rsp,
  input  soc_bus_pkg::bus_rsp_t shield_rsp,
  output soc_bus_pkg::bus_rsp_t host_rsp
);

  localparam int cnt_w = $clog2(TIMEOUT_CYCLES + 1);

  logic [cnt_w-1:0]      wait_cnt;
  logic                  any_ack;
  logic                  err_q;
  soc_bus_pkg::bus_rsp_t err_rsp;

  assign any_ack = mem_rsp.ack | led_rsp.ack | shield_rsp.ack;

  // Counts cycles of req without ack, no slave claimed the address
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_cnt <= '0;
      err_q    <= 1'b0;
    end
    else
    begin
      err_q <= 1'b0;
      if (!host_req.req || any_ack || err_q)
        wait_cnt <= '0;
      else if (wait_cnt == cnt_w'(TIMEOUT_CYCLES - 1))
      begin
        wait_cnt <= '0;
        err_q    <= 1'b1;
      end
      else
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign err_rsp = '{ack: err_q, err: err_q, rdata: '0};

  // Idle slaves drive zeros so a plain OR merges them
  assign host_rsp = mem_rsp | led_rsp | shield_rsp | err_rsp;

endmodule

//--- soc_top.sv
`timescale 1ns/10ps

module soc_top #(
  parameter int                              MEM_ADDR_BITS  = 10,
  parameter logic [soc_bus_pkg::addr_w-1:0] MEM_BASE       = 32'h0001_0000,
  parameter logic [soc_bus_pkg::addr_w-1:0] LED_BASE       = 32'hC000_0000,
  parameter logic [soc_bus_pkg::addr_w-1:0] SHIELD_BASE    = 32'hC000_1000,
  parameter int                              SCK_DIV        = 2,
  parameter int                              TIMEOUT_CYCLES = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  soc_bus_pkg::bus_req_t host_req,
  output soc_bus_pkg::bus_rsp_t host_rsp,
  output logic [7:0]            led,
  output logic                  adc_convst,
  output logic                  adc_sck,
  output logic                  adc_sdi,
  input  logic                  adc_sdo,
  input  logic [15:0]           gpio_in,
  output logic [15:0]           gpio_out,
  output logic [15:0]           gpio_oe
);

  logic [2:0]            rst_sync;
  logic                  rst_n;
  soc_bus_pkg::bus_rsp_t mem_rsp;
  soc_bus_pkg::bus_rsp_t led_rsp;
  soc_bus_pkg::bus_rsp_t shield_rsp;

  // Asserts at once, releases on the third clk edge
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rst_sync <= '0;
    else
      rst_sync <= {rst_sync[1:0], 1'b1};
  end

  assign rst_n = rst_sync[2];

  soc_mem #(
    .ADDR_BITS (MEM_ADDR_BITS),
    .BASE      (MEM_BASE)
  ) mem_i (
    .clk     (clk),
    .arst_n  (rst_n),
    .bus_req (host_req),
    .bus_rsp (mem_rsp)
  );

  soc_led #(
    .BASE (LED_BASE)
  ) led_i (
    .clk     (clk),
    .arst_n  (rst_n),
    .bus_req (host_req),
    .bus_rsp (led_rsp),
    .led     (led)
  );

  soc_shield #(
    .BASE    (SHIELD_BASE),
    .SCK_DIV (SCK_DIV)
  ) shield_i (
    .clk        (clk),
    .arst_n     (rst_n),
    .bus_req    (host_req),
    .bus_rsp    (shield_rsp),
    .adc_convst (adc_convst),
    .adc_sck    (adc_sck),
    .adc_sdi    (adc_sdi),
    .adc_sdo    (adc_sdo),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe)
  );

  soc_bus_join #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) bus_join_i (
    .clk        (clk),
    .arst_n     (rst_n),
    .host_req   (host_req),
    .mem_rsp    (mem_rsp),
    .led_rsp    (led_rsp),
    .shield_rsp (shield_rsp),
    .host_rsp   (host_rsp)
  );

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever
      #(HALF_PERIOD) clk = !clk;
  end

  // Reset held low for RESET_CYCLES rising edges
  initial
  begin
    arst_n <= 1'b0;
    repeat (RESET_CYCLES)
      @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- tb_top.sv
`timescale 1ns/10ps

module tb_top;

  localparam logic [31:0] mem_base    = 32'h0001_0000;
  localparam logic [31:0] led_base    = 32'hC000_0000;
  localparam logic [31:0] shield_base = 32'hC000_1000;
  localparam logic [31:0] seed        = 32'h4074_eb25;
  localparam int          ack_limit   = 64;
  localparam int          poll_limit  = 64;

  logic                  clk;
  logic                  arst_n;
  soc_bus_pkg::bus_req_t host_req;
  soc_bus_pkg::bus_rsp_t host_rsp;
  logic [7:0]            led;
  logic                  adc_convst;
  logic                  adc_sck;
  logic                  adc_sdi;
  logic                  adc_sdo;
  logic [15:0]           gpio_in;
  logic [15:0]           gpio_out;
  logic [15:0]           gpio_oe;
  logic [31:0]           rng_state;
  logic [11:0]           adc_table [8];

  tb_clock clock_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  soc_top #(
    .MEM_ADDR_BITS  (10),
    .MEM_BASE       (mem_base),
    .LED_BASE       (led_base),
    .SHIELD_BASE    (shield_base),
    .SCK_DIV        (2),
    .TIMEOUT_CYCLES (16)
  ) soc_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_req   (host_req),
    .host_rsp   (host_rsp),
    .led        (led),
    .adc_convst (adc_convst),
    .adc_sck    (adc_sck),
    .adc_sdi    (adc_sdi),
    .adc_sdo    (adc_sdo),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] mem_addr(input logic [7:0] idx);
    return mem_base + {22'h0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] shield_addr(input logic [11:0] offset);
    return shield_base | {20'h0, offset};
  endfunction

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input soc_bus_pkg::bus_rsp_t got,
                           input soc_bus_pkg::bus_rsp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_status(input string name, input soc_periph_pkg::adc_status_t got,
                              input soc_periph_pkg::adc_status_t exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_vec16(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
      @(posedge clk);
  endtask

  // One transfer, req dropped on the edge that shows ack
  task automatic bus_xfer(input logic wr, input logic [3:0] be, input logic [31:0] addr,
                          input logic [31:0] wdata, output soc_bus_pkg::bus_rsp_t rsp);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rsp     = '0;
    @(posedge clk);
    host_req <= '{req: 1'b1, write: wr, be: be, addr: addr, wdata: wdata};
    while (!got_ack && waited < ack_limit)
    begin
      @(posedge clk);
      waited++;
      if (host_rsp.ack)
      begin
        got_ack = 1'b1;
        rsp     = host_rsp;
      end
    end
    if (!got_ack)
      stop_on_error($sformatf("No ack within %0d cycles for address %h", ack_limit, addr));
    else
      host_req <= '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be, input logic exp_err);
    soc_bus_pkg::bus_rsp_t rsp;
    soc_bus_pkg::bus_rsp_t exp;
    exp = '{ack: 1'b1, err: exp_err, rdata: '0};
    bus_xfer(1'b1, be, addr, data, rsp);
    // Read data on a mapped write carries no meaning
    if (!exp_err)
      rsp.rdata = '0;
    check_rsp("write response", rsp, exp);
  endtask

  task automatic bus_read(input logic [31:0] addr, output soc_bus_pkg::bus_rsp_t rsp);
    bus_xfer(1'b0, 4'hF, addr, 32'h0, rsp);
  endtask

  task automatic read_check(input string name, input logic [31:0] addr,
                            input logic [31:0] data);
    soc_bus_pkg::bus_rsp_t rsp;
    soc_bus_pkg::bus_rsp_t exp;
    exp = '{ack: 1'b1, err: 1'b0, rdata: data};
    bus_read(addr, rsp);
    check_rsp(name, rsp, exp);
  endtask

  task automatic expect_no_ack(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      @(posedge clk);
      if (host_rsp.ack)
        stop_on_error("A second ack arrived after the error response");
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (!arst_n && waited < 32)
    begin
      @(posedge clk);
      waited++;
    end
    if (!arst_n)
      stop_on_error("Reset was never released");
    else
      wait_cycles(4);
    check_rsp("host_rsp after reset", host_rsp, '0);
    check_vec16("gpio_out after reset", gpio_out, 16'h0);
    check_vec16("gpio_oe after reset", gpio_oe, 16'h0);
    check_vec16("adc pins after reset", {13'h0, adc_convst, adc_sck, adc_sdi}, 16'h0);
  endtask

  task automatic test_memory();
    logic [31:0] shadow [256];
    logic [7:0]  addr_q [$];
    logic [31:0] r;
    logic [7:0]  idx;
    logic [3:0]  be;
    for (int i = 0; i < 12; i++)
    begin
      r   = next_random();
      idx = r[15:8];
      r   = next_random();
      bus_write(mem_addr(idx), r, 4'hF, 1'b0);
      shadow[idx] = r;
      addr_q.push_back(idx);
    end
    foreach (addr_q[i])
      read_check("mem rdata", mem_addr(addr_q[i]), shadow[addr_q[i]]);
    // Single lane writes leave the other bytes alone
    for (int k = 0; k < 8; k++)
    begin
      idx = addr_q[k];
      be  = 4'b0001 << (k % 4);
      r   = next_random();
      bus_write(mem_addr(idx), r, be, 1'b0);
      for (int b = 0; b < 4; b++)
      begin
        if (be[b])
          shadow[idx][8*b +: 8] = r[8*b +: 8];
      end
      read_check("mem rdata after byte write", mem_addr(idx), shadow[idx]);
    end
  endtask

  task automatic test_led();
    logic [31:0] r;
    read_check("led rdata after reset", led_base, 32'h0);
    check_vec16("led", {8'h00, led}, 16'h0);
    r = next_random();
    bus_write(led_base, r, 4'hF, 1'b0);
    check_vec16("led", {8'h00, led}, {8'h00, r[7:0]});
    read_check("led rdata", led_base, {24'h0, r[7:0]});
    bus_write(led_base, ~r, 4'hE, 1'b0);
    check_vec16("led without lane 0", {8'h00, led}, {8'h00, r[7:0]});
  endtask

  task automatic test_gpio();
    logic [31:0] r;
    r = next_random();
    bus_write(shield_addr(soc_periph_pkg::reg_gpio_out), r, 4'h3, 1'b0);
    check_vec16("gpio_out", gpio_out, r[15:0]);
    bus_write(shield_addr(soc_periph_pkg::reg_gpio_oe), {16'h0, r[31:16]}, 4'h3, 1'b0);
    check_vec16("gpio_oe", gpio_oe, r[31:16]);
    read_check("gpio_out rdata", shield_addr(soc_periph_pkg::reg_gpio_out), {16'h0, r[15:0]});
    read_check("gpio_oe rdata", shield_addr(soc_periph_pkg::reg_gpio_oe), {16'h0, r[31:16]});
    r = next_random();
    @(posedge clk);
    gpio_in <= r[15:0];
    // Two flops on the way in
    wait_cycles(3);
    read_check("gpio_in rdata", shield_addr(soc_periph_pkg::reg_gpio_in), {16'h0, r[15:0]});
  endtask

  task automatic run_conversion(input logic [2:0] ch, input logic second_start,
                                output soc_periph_pkg::adc_status_t st);
    soc_bus_pkg::bus_rsp_t rsp;
    logic [31:0]           data;
    int                    polls;
    logic                  done;
    data = '0;
    data[2:0] = ch;
    data[soc_periph_pkg::ctrl_start_bit] = 1'b1;
    bus_write(shield_addr(soc_periph_pkg::reg_ctrl), data, 4'h1, 1'b0);
    if (second_start)
    begin
      data[2:0] = ~ch;
      bus_write(shield_addr(soc_periph_pkg::reg_ctrl), data, 4'h1, 1'b0);
    end
    polls = 0;
    done  = 1'b0;
    st    = '0;
    while (!done && polls < poll_limit)
    begin
      bus_read(shield_addr(soc_periph_pkg::reg_status), rsp);
      st    = rsp.rdata[16:0];
      done  = !st.busy;
      polls++;
    end
    if (!done)
      stop_on_error($sformatf("ADC still busy after %0d status reads", poll_limit));
  endtask

  // The device returns the sample of the channel set up in the conversion before
  task automatic test_adc();
    soc_periph_pkg::adc_status_t st;
    soc_periph_pkg::adc_status_t exp;
    logic [2:0]                  held;
    held = 3'd0;
    for (int c = 0; c < 16; c++)
    begin
      run_conversion(3'(c / 2), 1'b0, st);
      exp = '{busy: 1'b0, valid: 1'b1, channel: 3'(c / 2), sample: adc_table[held]};
      check_status("adc status", st, exp);
      held = 3'(c / 2);
    end
    run_conversion(3'd5, 1'b1, st);
    exp = '{busy: 1'b0, valid: 1'b1, channel: 3'd5, sample: adc_table[held]};
    check_status("adc status after start while busy", st, exp);
  endtask

  task automatic test_unmapped();
    soc_bus_pkg::bus_rsp_t rsp;
    soc_bus_pkg::bus_rsp_t err_rsp;
    logic [31:0]           r;
    err_rsp = '{ack: 1'b1, err: 1'b1, rdata: '0};
    bus_read(32'h8000_0000, rsp);
    check_rsp("unmapped read response", rsp, err_rsp);
    expect_no_ack(40);
    r = next_random();
    bus_write(led_base + 32'h4, r, 4'hF, 1'b1);
    expect_no_ack(40);
    bus_write(mem_addr(8'h3C), r, 4'hF, 1'b0);
    read_check("mem rdata after error", mem_addr(8'h3C), r);
  endtask

  // ADC device model, captures the config on SCK falls and shifts SDO on rises
  initial
  begin
    logic                     sck_q;
    logic                     sdi_q;
    logic                     rise;
    logic                     fall;
    logic                     bit_in;
    logic [2:0]               cfg_cnt;
    logic [5:0]               cfg_sr;
    logic [2:0]               dev_ch;
    logic [11:0]              sdo_sr;
    soc_periph_pkg::adc_cfg_t cfg;
    sck_q   = 1'b0;
    sdi_q   = 1'b0;
    cfg_cnt = '0;
    cfg_sr  = '0;
    dev_ch  = '0;
    sdo_sr  = '0;
    adc_sdo <= 1'b0;
    forever
    begin
      @(posedge clk);
      rise   = !sck_q && adc_sck;
      fall   = sck_q && !adc_sck;
      bit_in = sdi_q;
      sck_q  = adc_sck;
      sdi_q  = adc_sdi;
      if (adc_convst)
      begin
        cfg_cnt = '0;
        sdo_sr  = adc_table[dev_ch];
        adc_sdo <= sdo_sr[11];
      end
      else if (rise)
      begin
        sdo_sr  = {sdo_sr[10:0], 1'b0};
        adc_sdo <= sdo_sr[11];
      end
      else if (fall && cfg_cnt < 3'd6)
      begin
        cfg_sr  = {cfg_sr[4:0], bit_in};
        cfg_cnt = cfg_cnt + 3'd1;
        if (cfg_cnt == 3'd6)
        begin
          cfg = cfg_sr;
          if (!cfg.single_ended || !cfg.unipolar || cfg.sleep)
            stop_on_error("ADC config word on SDI has wrong fixed bits");
          else
            dev_ch = {cfg.select, cfg.odd_sign};
        end
      end
    end
  end

  initial
  begin
    logic [31:0] r;
    host_req <= '0;
    gpio_in  <= '0;
    rng_state = seed;
    for (int i = 0; i < 8; i++)
    begin
      r = next_random();
      adc_table[i] = r[11:0];
    end
    wait_reset_release();
    test_memory();
    test_led();
    test_gpio();
    test_adc();
    test_unmapped();
    $display("sim passed");
    $finish;
  end

endmodule

//--- tb.f
soc_bus_pkg.sv
soc_periph_pkg.sv
soc_mem.sv
soc_led.sv
soc_adc_ctrl.sv
soc_shield.sv
soc_bus_join.sv
soc_top.sv
tb_clock.sv
tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f
./obj_dir/Vtb_top 2>&1 | tee sim.log
if grep -qx "sim passed" sim.log
then
  echo "RESULT: PASS"
else
  echo "RESULT: FAIL"
  exit 1
fi
